// ==== logic/exe_pkg.sv ====
package exe_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_JIRL,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_op_t;

    typedef enum logic [1:0] {
        MUL_LO,
        MULH_SS,
        MULH_UU
    } mul_op_t;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ALU,
        UNIT_MUL,
        UNIT_BR
    } unit_t;

    // pc_next is the predicted next pc from fetch
    typedef struct packed {
        logic              en;
        unit_t             unit;
        alu_op_t           alu_op;
        br_op_t            br_op;
        mul_op_t           mul_op;
        logic              use_imm;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rj;
        logic [REG_AW-1:0] rk;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   pc_next;
    } issue_slot_t;

    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic            flush;
        logic [XLEN-1:0] target;
    } redirect_t;

    // hh already carries the signed correction
    typedef struct packed {
        logic [XLEN-1:0] ll;
        logic [XLEN-1:0] lh;
        logic [XLEN-1:0] hl;
        logic [XLEN-1:0] hh;
        mul_op_t         op;
    } mul_part_t;

endpackage

// ==== logic/exe_alu.sv ====
`timescale 1ns/10ps

module exe_alu import exe_pkg::*; (
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result
);

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0] shamt;

    assign shamt = b[SHW-1:0];

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR: result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, a < b};
            end
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            ALU_SRA: result = $unsigned($signed(a) >>> shamt);
            // upper immediate comes in pre-shifted
            ALU_LUI: result = b;
            default: result = '0;
        endcase
    end

endmodule

// ==== logic/exe_branch.sv ====
`timescale 1ns/10ps

module exe_branch import exe_pkg::*; (
    input  issue_slot_t     slot,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output redirect_t       redirect,
    output logic [XLEN-1:0] link
);

    logic            taken;
    logic            is_br;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] next_pc;

    always_comb begin
        case (slot.br_op)
            BR_JIRL,
            BR_B,
            BR_BL: taken = 1'b1;
            BR_BEQ: taken = (a == b);
            BR_BNE: taken = (a != b);
            BR_BLT: taken = ($signed(a) < $signed(b));
            BR_BGE: taken = ($signed(a) >= $signed(b));
            BR_BLTU: taken = (a < b);
            BR_BGEU: taken = (a >= b);
            default: taken = 1'b0;
        endcase
    end

    // jirl is register relative and the rest pc relative
    assign target = (slot.br_op == BR_JIRL) ? a + slot.imm : slot.pc + slot.imm;

    assign link    = slot.pc + XLEN'(4);
    assign next_pc = taken ? target : link;

    assign is_br = slot.en && (slot.unit == UNIT_BR);

    // mispredict when the real next pc differs from the prediction
    assign redirect.flush  = is_br && (next_pc != slot.pc_next);
    assign redirect.target = next_pc;

endmodule

// ==== logic/exe_mul.sv ====
`timescale 1ns/10ps

module exe_mul import exe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            advance,
    input  mul_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] product
);

    localparam int HALF = XLEN / 2;

    mul_part_t         part;
    logic [XLEN-1:0]   corr;
    logic [2*XLEN-1:0] sum;

    // signed high word = unsigned high word minus the cross terms
    always_comb begin
        corr = '0;
        if (op == MULH_SS) begin
            if (a[XLEN-1]) begin
                corr = corr + b;
            end
            if (b[XLEN-1]) begin
                corr = corr + a;
            end
        end
    end

    // four 16x16 products in the first cycle
    always_ff @(posedge clk) begin
        if (advance) begin
            part.ll <= a[HALF-1:0] * b[HALF-1:0];
            part.lh <= a[HALF-1:0] * b[XLEN-1:HALF];
            part.hl <= a[XLEN-1:HALF] * b[HALF-1:0];
            part.hh <= a[XLEN-1:HALF] * b[XLEN-1:HALF] - corr;
            part.op <= op;
        end
    end

    // final sum and word select in the second cycle
    assign sum = {part.hh, part.ll}
               + ({{XLEN{1'b0}}, part.lh} << HALF)
               + ({{XLEN{1'b0}}, part.hl} << HALF);

    assign product = (part.op == MUL_LO) ? sum[XLEN-1:0] : sum[2*XLEN-1:XLEN];

    a_op_known: assert property (
        @(posedge clk) disable iff (reset)
        advance |-> !$isunknown(op)
    );

endmodule

// ==== logic/exe_forward.sv ====
`timescale 1ns/10ps

module exe_forward import exe_pkg::*; (
    input  issue_slot_t     slot0,
    input  issue_slot_t     slot1,
    input  logic [XLEN-1:0] rj0_data,
    input  logic [XLEN-1:0] rk0_data,
    input  logic [XLEN-1:0] rj1_data,
    input  logic [XLEN-1:0] rk1_data,
    input  wb_t             exe1_wb0,
    input  wb_t             exe1_wb1,
    input  wb_t             wb0,
    input  wb_t             wb1,
    output logic [XLEN-1:0] op_a0,
    output logic [XLEN-1:0] op_b0,
    output logic [XLEN-1:0] op_a1,
    output logic [XLEN-1:0] op_b1
);

    // youngest result wins
    function automatic logic [XLEN-1:0] pick(
        input logic [REG_AW-1:0] r,
        input logic [XLEN-1:0]   rf
    );
        if (r == '0) begin
            return '0;
        end else if (exe1_wb1.en && exe1_wb1.rd == r) begin
            return exe1_wb1.data;
        end else if (exe1_wb0.en && exe1_wb0.rd == r) begin
            return exe1_wb0.data;
        end else if (wb1.en && wb1.rd == r) begin
            return wb1.data;
        end else if (wb0.en && wb0.rd == r) begin
            return wb0.data;
        end
        return rf;
    endfunction

    always_comb begin
        op_a0 = pick(slot0.rj, rj0_data);
        op_b0 = slot0.use_imm ? slot0.imm : pick(slot0.rk, rk0_data);
        op_a1 = pick(slot1.rj, rj1_data);
        op_b1 = slot1.use_imm ? slot1.imm : pick(slot1.rk, rk1_data);
    end

endmodule

// ==== logic/exe_control.sv ====
`timescale 1ns/10ps

module exe_control import exe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  issue_slot_t       slot0,
    input  issue_slot_t       slot1,
    input  logic              br_flush,
    input  logic [REG_AW-1:0] mul_rd,
    input  logic              mul_busy,
    output logic              issue_ready,
    output logic              accept,
    output logic              kill1,
    output logic              flush_q
);

    logic mul_hazard;

    function automatic logic reads_rd(
        input issue_slot_t       s,
        input logic [REG_AW-1:0] r
    );
        return s.en && ((s.rj == r) || (!s.use_imm && (s.rk == r)));
    endfunction

    // product not ready until writeback so issue holds one cycle
    assign mul_hazard = mul_busy && (mul_rd != '0)
                     && (reads_rd(slot0, mul_rd) || reads_rd(slot1, mul_rd));

    assign issue_ready = !flush_q && !mul_hazard;
    assign accept      = issue_valid && issue_ready;

    // lane 1 shares the group with a mispredicted branch
    assign kill1 = accept && br_flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= accept && br_flush;
        end
    end

    a_no_issue_in_flush: assert property (
        @(posedge clk) disable iff (reset)
        (accept && br_flush) |=> (flush_q && !issue_ready)
    );

    a_accept_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        accept |-> issue_valid
    );

endmodule

// ==== logic/exe_results.sv ====
`timescale 1ns/10ps

module exe_results import exe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              accept,
    input  logic              kill1,
    input  issue_slot_t       slot0,
    input  issue_slot_t       slot1,
    input  logic [XLEN-1:0]   alu0,
    input  logic [XLEN-1:0]   alu1,
    input  logic [XLEN-1:0]   link,
    input  redirect_t         br_redirect,
    input  logic [XLEN-1:0]   product,
    output wb_t               exe1_wb0,
    output wb_t               exe1_wb1,
    output logic [REG_AW-1:0] mul_rd,
    output logic              mul_busy,
    output wb_t               wb0,
    output wb_t               wb1,
    output redirect_t         redirect
);

    logic is_link;
    logic wr0;
    logic wr1;

    // only bl and jirl write a link register
    assign is_link = (slot0.unit == UNIT_BR)
                  && ((slot0.br_op == BR_BL) || (slot0.br_op == BR_JIRL));

    assign wr0 = accept && slot0.en && (slot0.rd != '0)
              && ((slot0.unit == UNIT_ALU) || is_link);
    assign wr1 = accept && slot1.en && !kill1 && (slot1.rd != '0)
              && (slot1.unit == UNIT_ALU);

    always_ff @(posedge clk) begin
        if (reset) begin
            exe1_wb0.en     <= 1'b0;
            exe1_wb1.en     <= 1'b0;
            mul_busy        <= 1'b0;
            wb0.en          <= 1'b0;
            wb1.en          <= 1'b0;
            redirect.flush  <= 1'b0;
        end else begin
            exe1_wb0.en     <= wr0;
            exe1_wb1.en     <= wr1;
            mul_busy        <= accept && slot0.en && (slot0.unit == UNIT_MUL);
            wb0.en          <= exe1_wb0.en || (mul_busy && (mul_rd != '0));
            wb1.en          <= exe1_wb1.en;
            redirect.flush  <= accept && br_redirect.flush;
        end
    end

    always_ff @(posedge clk) begin
        exe1_wb0.rd     <= slot0.rd;
        exe1_wb0.data   <= (slot0.unit == UNIT_BR) ? link : alu0;
        exe1_wb1.rd     <= slot1.rd;
        exe1_wb1.data   <= alu1;
        mul_rd          <= slot0.rd;
        // a multiply owns lane 0 of writeback when its product lands
        wb0.rd          <= mul_busy ? mul_rd : exe1_wb0.rd;
        wb0.data        <= mul_busy ? product : exe1_wb0.data;
        wb1.rd          <= exe1_wb1.rd;
        wb1.data        <= exe1_wb1.data;
        redirect.target <= br_redirect.target;
    end

    a_no_r0_write: assert property (
        @(posedge clk) disable iff (reset)
        !(wb0.en && (wb0.rd == '0)) && !(wb1.en && (wb1.rd == '0))
    );

endmodule

// ==== logic/exe_top.sv ====
`timescale 1ns/10ps

module exe_top import exe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            issue_valid,
    input  issue_slot_t     slot0,
    input  issue_slot_t     slot1,
    input  logic [XLEN-1:0] rj0_data,
    input  logic [XLEN-1:0] rk0_data,
    input  logic [XLEN-1:0] rj1_data,
    input  logic [XLEN-1:0] rk1_data,
    output logic            issue_ready,
    output wb_t             wb0,
    output wb_t             wb1,
    output redirect_t       redirect
);

    logic              accept;
    logic              kill1;
    logic              mul_busy;
    logic              mul_advance;
    logic [REG_AW-1:0] mul_rd;
    logic [XLEN-1:0]   op_a0;
    logic [XLEN-1:0]   op_b0;
    logic [XLEN-1:0]   op_a1;
    logic [XLEN-1:0]   op_b1;
    logic [XLEN-1:0]   alu0;
    logic [XLEN-1:0]   alu1;
    logic [XLEN-1:0]   link;
    logic [XLEN-1:0]   product;
    redirect_t         br_redirect;
    wb_t               exe1_wb0;
    wb_t               exe1_wb1;

    assign mul_advance = accept && slot0.en && (slot0.unit == UNIT_MUL);

    exe_control u_control (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .slot0       (slot0),
        .slot1       (slot1),
        .br_flush    (br_redirect.flush),
        .mul_rd      (mul_rd),
        .mul_busy    (mul_busy),
        .issue_ready (issue_ready),
        .accept      (accept),
        .kill1       (kill1),
        .flush_q     ()
    );

    exe_forward u_forward (
        .slot0    (slot0),
        .slot1    (slot1),
        .rj0_data (rj0_data),
        .rk0_data (rk0_data),
        .rj1_data (rj1_data),
        .rk1_data (rk1_data),
        .exe1_wb0 (exe1_wb0),
        .exe1_wb1 (exe1_wb1),
        .wb0      (wb0),
        .wb1      (wb1),
        .op_a0    (op_a0),
        .op_b0    (op_b0),
        .op_a1    (op_a1),
        .op_b1    (op_b1)
    );

    exe_alu u_alu0 (
        .op     (slot0.alu_op),
        .a      (op_a0),
        .b      (op_b0),
        .result (alu0)
    );

    exe_alu u_alu1 (
        .op     (slot1.alu_op),
        .a      (op_a1),
        .b      (op_b1),
        .result (alu1)
    );

    exe_branch u_branch (
        .slot     (slot0),
        .a        (op_a0),
        .b        (op_b0),
        .redirect (br_redirect),
        .link     (link)
    );

    exe_mul u_mul (
        .clk     (clk),
        .reset   (reset),
        .advance (mul_advance),
        .op      (slot0.mul_op),
        .a       (op_a0),
        .b       (op_b0),
        .product (product)
    );

    exe_results u_results (
        .clk         (clk),
        .reset       (reset),
        .accept      (accept),
        .kill1       (kill1),
        .slot0       (slot0),
        .slot1       (slot1),
        .alu0        (alu0),
        .alu1        (alu1),
        .link        (link),
        .br_redirect (br_redirect),
        .product     (product),
        .exe1_wb0    (exe1_wb0),
        .exe1_wb1    (exe1_wb1),
        .mul_rd      (mul_rd),
        .mul_busy    (mul_busy),
        .wb0         (wb0),
        .wb1         (wb1),
        .redirect    (redirect)
    );

endmodule

// ==== sim/exe_tb_table.svh ====
`ifndef EXE_TB_TABLE_SVH
`define EXE_TB_TABLE_SVH

// row columns are name, slot0, slot1, rj0, rk0, rj1, rk1, stall cycles, wb0, wb1, redirect
// dead values on the register file ports must be replaced by forwarding
task automatic load_table;
    table_rows.push_back(make_row("add_imm", alu_slot(ALU_ADD, 1, 0, 0, 1, 5),
        alu_slot(ALU_ADD, 2, 3, 0, 1, 100), 32'hdead0000, 32'hdead0000, 32'd7, 32'hdead0000,
        0, wbv(1, 32'd5), wbv(2, 32'd107), '0));
    table_rows.push_back(make_row("fwd_exe1", alu_slot(ALU_SUB, 4, 1, 2, 0, 0),
        alu_slot(ALU_XOR, 5, 2, 0, 1, 32'hff), 32'hdead0001, 32'hdead0001, 32'hdead0001,
        32'hdead0001, 0, wbv(4, 32'hffffff9a), wbv(5, 32'h94), '0));
    table_rows.push_back(make_row("fwd_wb", alu_slot(ALU_OR, 6, 1, 4, 0, 0),
        alu_slot(ALU_SLL, 7, 2, 0, 1, 4), 32'hdead0002, 32'hdead0002, 32'hdead0002,
        32'hdead0002, 0, wbv(6, 32'hffffff9f), wbv(7, 32'h6b0), '0));
    table_rows.push_back(make_row("fwd_mix", alu_slot(ALU_SRA, 8, 4, 0, 1, 4),
        alu_slot(ALU_SLT, 9, 5, 7, 0, 0), 32'hdead0003, 32'hdead0003, 32'hdead0003,
        32'hdead0003, 0, wbv(8, 32'hfffffff9), wbv(9, 32'd1), '0));
    table_rows.push_back(make_row("rf_read", alu_slot(ALU_SRL, 10, 1, 0, 1, 1),
        alu_slot(ALU_SLTU, 11, 12, 13, 0, 0), 32'd5, 32'hdead0004, 32'hffff0000, 32'd1,
        0, wbv(10, 32'd2), wbv(11, 32'd0), '0));
    table_rows.push_back(make_row("mul_lo", mul_slot(MUL_LO, 12, 13, 14),
        alu_slot(ALU_LUI, 15, 0, 0, 1, 32'habcde000), 32'h12345678, 32'h10, 32'hdead0005,
        32'hdead0005, 0, wbv(12, 32'h23456780), wbv(15, 32'habcde000), '0));
    table_rows.push_back(make_row("mul_use", alu_slot(ALU_ADD, 16, 12, 0, 1, 1),
        alu_slot(ALU_AND, 17, 15, 0, 1, 32'hffff0000), 32'hdead0006, 32'hdead0006,
        32'hdead0006, 32'hdead0006, 1, wbv(16, 32'h23456781), wbv(17, 32'habcd0000), '0));
    table_rows.push_back(make_row("mulh_ss", mul_slot(MULH_SS, 18, 19, 20), '0,
        32'hfffffffe, 32'd3, 32'd0, 32'd0, 0, wbv(18, 32'hffffffff), '0, '0));
    table_rows.push_back(make_row("mulh_uu", mul_slot(MULH_UU, 19, 21, 22), '0,
        32'hffffffff, 32'd2, 32'd0, 32'd0, 0, wbv(19, 32'd1), '0, '0));
    table_rows.push_back(make_row("mulh_ss_mix", mul_slot(MULH_SS, 21, 23, 24), '0,
        32'h80000000, 32'h7fffffff, 32'd0, 32'd0, 0, wbv(21, 32'hc0000000), '0, '0));
    table_rows.push_back(make_row("br_ok", br_slot(BR_BEQ, 0, 0, 0, 32'h40, 32'h1000, 32'h1040),
        alu_slot(ALU_ADD, 22, 0, 0, 1, 9), 32'd0, 32'd0, 32'd0, 32'd0,
        0, '0, wbv(22, 32'd9), '0));
    table_rows.push_back(make_row("bne_mispred",
        br_slot(BR_BNE, 0, 23, 24, 32'h80, 32'h2000, 32'h2004),
        alu_slot(ALU_ADD, 25, 0, 0, 1, 3), 32'd1, 32'd2, 32'd0, 32'd0,
        0, '0, '0, redirect_t'{1'b1, 32'h2080}));
    table_rows.push_back(make_row("bl_after_flush",
        br_slot(BR_BL, 1, 0, 0, 32'h100, 32'h2080, 32'h2180),
        alu_slot(ALU_ADD, 26, 0, 0, 1, 4), 32'd0, 32'd0, 32'd0, 32'd0,
        1, wbv(1, 32'h2084), wbv(26, 32'd4), '0));
    table_rows.push_back(make_row("jirl_mispred",
        br_slot(BR_JIRL, 2, 1, 0, 32'h10, 32'h3000, 32'h3004),
        alu_slot(ALU_ADD, 27, 0, 0, 1, 5), 32'hdead0007, 32'd0, 32'd0, 32'd0,
        0, wbv(2, 32'h3004), '0, redirect_t'{1'b1, 32'h2094}));
    table_rows.push_back(make_row("blt_fallthru",
        br_slot(BR_BLT, 0, 3, 4, 32'h40, 32'h4000, 32'h4004), '0,
        32'd5, 32'd3, 32'd0, 32'd0, 1, '0, '0, '0));
    table_rows.push_back(make_row("bgeu_mispred",
        br_slot(BR_BGEU, 0, 29, 30, 32'h40, 32'h5000, 32'h5020),
        alu_slot(ALU_ADD, 28, 0, 0, 1, 6), 32'd1, 32'hffffffff, 32'd0, 32'd0,
        0, '0, '0, redirect_t'{1'b1, 32'h5004}));
    table_rows.push_back(make_row("drain", '0, '0, 32'd0, 32'd0, 32'd0, 32'd0,
        1, '0, '0, '0));
endtask

`endif

// ==== sim/exe_tb.sv ====
`timescale 1ns/10ps

module exe_tb import exe_pkg::*; ;

    typedef struct {
        string           name;
        issue_slot_t     s0;
        issue_slot_t     s1;
        logic [XLEN-1:0] rj0;
        logic [XLEN-1:0] rk0;
        logic [XLEN-1:0] rj1;
        logic [XLEN-1:0] rk1;
        int              stall;
        wb_t             e0;
        wb_t             e1;
        redirect_t       er;
    } row_t;

    logic            clk;
    logic            reset;
    logic            issue_valid;
    issue_slot_t     slot0;
    issue_slot_t     slot1;
    logic [XLEN-1:0] rj0_data;
    logic [XLEN-1:0] rk0_data;
    logic [XLEN-1:0] rj1_data;
    logic [XLEN-1:0] rk1_data;
    logic            issue_ready;
    wb_t             wb0;
    wb_t             wb1;
    redirect_t       redirect;

    int              errors;
    int              checks;
    int              cyc;
    wb_t             exp_wb0 [1024];
    wb_t             exp_wb1 [1024];
    redirect_t       exp_rdr [1024];
    string           wb_name [1024];
    string           rdr_name [1024];
    logic [XLEN-1:0] rf_mem [32];
    logic [XLEN-1:0] arch [32];
    logic [31:0]     rnd_state;
    row_t            table_rows [$];

    exe_top uut (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .slot0       (slot0),
        .slot1       (slot1),
        .rj0_data    (rj0_data),
        .rk0_data    (rk0_data),
        .rj1_data    (rj1_data),
        .rk1_data    (rk1_data),
        .issue_ready (issue_ready),
        .wb0         (wb0),
        .wb1         (wb1),
        .redirect    (redirect)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic wb_t wbv(input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] data);
        return wb_t'{1'b1, rd, data};
    endfunction

    function automatic issue_slot_t alu_slot(input alu_op_t op, input logic [REG_AW-1:0] rd,
            input logic [REG_AW-1:0] rj, input logic [REG_AW-1:0] rk,
            input logic use_imm, input logic [XLEN-1:0] imm);
        issue_slot_t s;
        s = '0;
        s.en = 1'b1;
        s.unit = UNIT_ALU;
        s.alu_op = op;
        s.rd = rd;
        s.rj = rj;
        s.rk = rk;
        s.use_imm = use_imm;
        s.imm = imm;
        return s;
    endfunction

    function automatic issue_slot_t mul_slot(input mul_op_t op, input logic [REG_AW-1:0] rd,
            input logic [REG_AW-1:0] rj, input logic [REG_AW-1:0] rk);
        issue_slot_t s;
        s = '0;
        s.en = 1'b1;
        s.unit = UNIT_MUL;
        s.mul_op = op;
        s.rd = rd;
        s.rj = rj;
        s.rk = rk;
        return s;
    endfunction

    function automatic issue_slot_t br_slot(input br_op_t op, input logic [REG_AW-1:0] rd,
            input logic [REG_AW-1:0] rj, input logic [REG_AW-1:0] rk,
            input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc,
            input logic [XLEN-1:0] pc_next);
        issue_slot_t s;
        s = '0;
        s.en = 1'b1;
        s.unit = UNIT_BR;
        s.br_op = op;
        s.rd = rd;
        s.rj = rj;
        s.rk = rk;
        s.imm = imm;
        s.pc = pc;
        s.pc_next = pc_next;
        return s;
    endfunction

    function automatic row_t make_row(input string name, input issue_slot_t s0,
            input issue_slot_t s1, input logic [XLEN-1:0] rj0, input logic [XLEN-1:0] rk0,
            input logic [XLEN-1:0] rj1, input logic [XLEN-1:0] rk1, input int stall,
            input wb_t e0, input wb_t e1, input redirect_t er);
        row_t r;
        r.name = name;
        r.s0 = s0;
        r.s1 = s1;
        r.rj0 = rj0;
        r.rk0 = rk0;
        r.rj1 = rj1;
        r.rk1 = rk1;
        r.stall = stall;
        r.e0 = e0;
        r.e1 = e1;
        r.er = er;
        return r;
    endfunction

    // reference ALU
    function automatic logic [XLEN-1:0] ref_alu(input alu_op_t op, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR: return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SRA: return 32'($signed(a) >>> b[4:0]);
            ALU_LUI: return b;
            default: return 32'd0;
        endcase
    endfunction

    `include "exe_tb_table.svh"

    task automatic compare(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // advance one cycle and check the registered outputs
    task automatic step_cycle;
        int idx;
        @(posedge clk);
        #1;
        cyc++;
        idx = cyc % 1024;
        compare({wb_name[idx], " wb0.en"}, 64'(exp_wb0[idx].en), 64'(wb0.en));
        if (exp_wb0[idx].en) begin
            compare({wb_name[idx], " wb0"}, 64'(exp_wb0[idx]), 64'(wb0));
            rf_mem[exp_wb0[idx].rd] = exp_wb0[idx].data;
        end
        compare({wb_name[idx], " wb1.en"}, 64'(exp_wb1[idx].en), 64'(wb1.en));
        if (exp_wb1[idx].en) begin
            compare({wb_name[idx], " wb1"}, 64'(exp_wb1[idx]), 64'(wb1));
            rf_mem[exp_wb1[idx].rd] = exp_wb1[idx].data;
        end
        compare({rdr_name[idx], " flush"}, 64'(exp_rdr[idx].flush), 64'(redirect.flush));
        if (exp_rdr[idx].flush) begin
            compare({rdr_name[idx], " target"}, 64'(exp_rdr[idx].target), 64'(redirect.target));
        end
        exp_wb0[idx] = '0;
        exp_wb1[idx] = '0;
        exp_rdr[idx] = '0;
        wb_name[idx] = "idle";
        rdr_name[idx] = "idle";
    endtask

    task automatic issue_row(input row_t r);
        int waits;
        issue_valid = 1'b1;
        slot0 = r.s0;
        slot1 = r.s1;
        rj0_data = r.rj0;
        rk0_data = r.rk0;
        rj1_data = r.rj1;
        rk1_data = r.rk1;
        waits = 0;
        @(negedge clk);
        while (!issue_ready && waits <= 10) begin
            waits++;
            step_cycle();
            @(negedge clk);
        end
        if (waits > 10) begin
            $display("timeout: group %s was never accepted", r.name);
            $display("Simulation FAILED");
            $finish;
        end else begin
            compare({r.name, " stall cycles"}, 64'(r.stall), 64'(waits));
            exp_wb0[(cyc + 2) % 1024] = r.e0;
            exp_wb1[(cyc + 2) % 1024] = r.e1;
            wb_name[(cyc + 2) % 1024] = r.name;
            exp_rdr[(cyc + 1) % 1024] = r.er;
            rdr_name[(cyc + 1) % 1024] = r.name;
            step_cycle();
        end
    endtask

    task automatic idle_cycles(input int n);
        issue_valid = 1'b0;
        slot0 = '0;
        slot1 = '0;
        repeat (n) step_cycle();
    endtask

    // random ALU groups with lane 1 on r16..r31 so it never reads lane 0's rd
    task automatic random_group;
        issue_slot_t s0;
        issue_slot_t s1;
        logic [XLEN-1:0] r0;
        logic [XLEN-1:0] r1;
        rnd_state = xorshift32(rnd_state);
        s0 = alu_slot(alu_op_t'(4'(rnd_state % 11)), 5'(1 + (rnd_state >> 4) % 15),
            5'(rnd_state >> 9), 5'(rnd_state >> 14), rnd_state[31], 32'd0);
        rnd_state = xorshift32(rnd_state);
        s0.imm = rnd_state;
        rnd_state = xorshift32(rnd_state);
        s1 = alu_slot(alu_op_t'(4'(rnd_state % 11)), 5'(16 + (rnd_state >> 4) % 16),
            5'(16 + (rnd_state >> 9) % 16), 5'(16 + (rnd_state >> 14) % 16),
            rnd_state[31], xorshift32(rnd_state ^ 32'h5a5a));
        r0 = ref_alu(s0.alu_op, arch[s0.rj], s0.use_imm ? s0.imm : arch[s0.rk]);
        r1 = ref_alu(s1.alu_op, arch[s1.rj], s1.use_imm ? s1.imm : arch[s1.rk]);
        arch[s0.rd] = r0;
        arch[s1.rd] = r1;
        issue_row(make_row("random", s0, s1, rf_mem[s0.rj], rf_mem[s0.rk], rf_mem[s1.rj],
            rf_mem[s1.rk], 0, wbv(s0.rd, r0), wbv(s1.rd, r1), '0));
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        issue_valid = 1'b0;
        slot0 = '0;
        slot1 = '0;
        rj0_data = '0;
        rk0_data = '0;
        rj1_data = '0;
        rk1_data = '0;
        errors = 0;
        checks = 0;
        cyc = 0;
        rnd_state = 32'he0f9;
        for (int i = 0; i < 1024; i++) begin
            exp_wb0[i] = '0;
            exp_wb1[i] = '0;
            exp_rdr[i] = '0;
            wb_name[i] = "idle";
            rdr_name[i] = "reset";
        end
        for (int i = 0; i < 32; i++) begin
            rf_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        compare("reset issue_ready", 64'd1, 64'(issue_ready));
        idle_cycles(2);

        load_table();
        foreach (table_rows[i]) begin
            issue_row(table_rows[i]);
        end
        idle_cycles(4);

        // fresh register state for the random phase
        for (int i = 0; i < 32; i++) begin
            rnd_state = xorshift32(rnd_state);
            arch[i] = (i == 0) ? 32'd0 : rnd_state;
            rf_mem[i] = arch[i];
        end
        repeat (200) random_group();
        idle_cycles(4);

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #2ms;
        $display("timeout: simulation ran past its time limit");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+sim
logic/exe_pkg.sv
logic/exe_alu.sv
logic/exe_branch.sv
logic/exe_mul.sv
logic/exe_forward.sv
logic/exe_control.sv
logic/exe_results.sv
logic/exe_top.sv
sim/exe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP       := exe_tb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
